//--- common/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    localparam int XLEN = 32;

    // funct7 for SUB and SRA
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SRL  = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        MUL_MUL    = 3'b000,
        MUL_MULH   = 3'b001,
        MUL_MULHSU = 3'b010,
        MUL_MULHU  = 3'b011
    } mul_f3_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_f3_e;

    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_f3_e;

endpackage

`default_nettype wire

//--- common/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // which unit takes the order
    typedef enum logic [2:0] {
        EX_ALU    = 3'd0,
        EX_MUL    = 3'd1,
        EX_LOAD   = 3'd2,
        EX_STORE  = 3'd3,
        EX_JUMP   = 3'd4,
        EX_BRANCH = 3'd5,
        EX_SUBST  = 3'd6
    } exec_type_e;

    typedef enum logic [1:0] {
        MEM_IDLE = 2'd0,
        MEM_READ = 2'd1,
        MEM_DONE = 2'd2
    } mem_state_e;

endpackage

`default_nettype wire

//--- alu/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [2:0]                 func3,
    input  logic [6:0]                 func7,
    input  logic [riscv_pkg::XLEN-1:0] a,
    input  logic [riscv_pkg::XLEN-1:0] b,
    output logic [riscv_pkg::XLEN-1:0] y
);

    logic       alt;
    logic [4:0] shamt;

    assign alt   = (func7 == riscv_pkg::F7_ALT);
    assign shamt = b[4:0];

    always_comb begin
        case (riscv_pkg::alu_f3_e'(func3))
            riscv_pkg::ALU_ADD:  y = alt ? a - b : a + b;
            riscv_pkg::ALU_SLL:  y = a << shamt;
            riscv_pkg::ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
            riscv_pkg::ALU_SLTU: y = {31'b0, a < b};
            riscv_pkg::ALU_XOR:  y = a ^ b;
            // arithmetic shift keeps the sign bit
            riscv_pkg::ALU_SRL:  y = alt ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            riscv_pkg::ALU_OR:   y = a | b;
            riscv_pkg::ALU_AND:  y = a & b;
            default:             y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- alu/alu_mul.sv
`timescale 1ns/1ps
`default_nettype none

module alu_mul (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [2:0]                 func3,
    input  logic [riscv_pkg::XLEN-1:0] a,
    input  logic [riscv_pkg::XLEN-1:0] b,
    output logic                       done,
    output logic [riscv_pkg::XLEN-1:0] y
);

    logic        a_signed;
    logic        b_signed;
    logic [31:0] a_mag;
    logic [31:0] b_mag;
    logic        running;
    logic        fix;
    logic        load;
    logic [4:0]  cnt;
    logic [63:0] mcand;
    logic [63:0] acc;
    logic [63:0] prod;
    logic [31:0] mplier;
    logic        neg;
    logic        high;

    always_comb begin
        a_signed = 1'b0;
        b_signed = 1'b0;
        case (riscv_pkg::mul_f3_e'(func3))
            riscv_pkg::MUL_MULH: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            riscv_pkg::MUL_MULHSU: a_signed = 1'b1;
            default: ;
        endcase
    end

    assign a_mag = (a_signed && a[31]) ? -a : a;
    assign b_mag = (b_signed && b[31]) ? -b : b;
    assign load  = start & ~running & ~fix;

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            fix     <= 1'b0;
            cnt     <= '0;
        end else begin
            fix <= 1'b0;
            if (load) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 5'd1;
                if (cnt == 5'd31) begin
                    running <= 1'b0;
                    fix     <= 1'b1;
                end
            end
        end
    end

    // one shift-add step per cycle
    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= {32'b0, a_mag};
            mplier <= b_mag;
            acc    <= '0;
            neg    <= (a_signed & a[31]) ^ (b_signed & b[31]);
            high   <= (func3 != riscv_pkg::MUL_MUL);
        end else if (running) begin
            acc    <= acc + (mplier[0] ? mcand : 64'b0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // sign fix in the last cycle
    assign prod = neg ? -acc : acc;
    assign y    = high ? prod[63:32] : prod[31:0];
    assign done = fix;

endmodule

`default_nettype wire

//--- design/branch_cmp.sv
`timescale 1ns/1ps
`default_nettype none

module branch_cmp (
    input  logic [2:0]                 func3,
    input  logic [riscv_pkg::XLEN-1:0] a,
    input  logic [riscv_pkg::XLEN-1:0] b,
    output logic                       taken
);

    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (a == b);
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;

    always_comb begin
        case (riscv_pkg::br_f3_e'(func3))
            riscv_pkg::BR_EQ:  taken = eq;
            riscv_pkg::BR_NE:  taken = ~eq;
            riscv_pkg::BR_LT:  taken = lt;
            riscv_pkg::BR_GE:  taken = ~lt;
            riscv_pkg::BR_LTU: taken = ltu;
            riscv_pkg::BR_GEU: taken = ~ltu;
            default:           taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access #(
    parameter int MADDR_W = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       is_store,
    input  logic [2:0]                 func3,
    input  logic [riscv_pkg::XLEN-1:0] addr,
    input  logic [riscv_pkg::XLEN-1:0] sdata,
    input  logic [riscv_pkg::XLEN-1:0] mem_ld,
    output logic                       done,
    output logic [riscv_pkg::XLEN-1:0] rdata,
    output logic                       mem_en,
    output logic [3:0]                 mem_write,
    output logic [MADDR_W-1:0]         mem_a,
    output logic [riscv_pkg::XLEN-1:0] mem_sd
);

    exec_pkg::mem_state_e state;
    logic [2:0]           f3_q;
    logic [1:0]           off_q;
    logic [3:0]           lanes;
    logic [31:0]          lane_data;
    logic [31:0]          ext_data;

    always_comb begin
        case (riscv_pkg::ls_f3_e'(func3))
            riscv_pkg::LS_B: begin
                lanes  = 4'b0001 << addr[1:0];
                mem_sd = {4{sdata[7:0]}};
            end
            riscv_pkg::LS_H: begin
                lanes  = 4'b0011 << addr[1:0];
                mem_sd = {2{sdata[15:0]}};
            end
            default: begin
                lanes  = 4'b1111;
                mem_sd = sdata;
            end
        endcase
    end

    // request goes out in the accept cycle
    assign mem_en    = start;
    assign mem_write = (start && is_store) ? lanes : 4'b0000;
    assign mem_a     = addr[MADDR_W+1:2];

    assign lane_data = mem_ld >> {off_q, 3'b000};

    always_comb begin
        case (riscv_pkg::ls_f3_e'(f3_q))
            riscv_pkg::LS_B:  ext_data = {{24{lane_data[7]}}, lane_data[7:0]};
            riscv_pkg::LS_BU: ext_data = {24'b0, lane_data[7:0]};
            riscv_pkg::LS_H:  ext_data = {{16{lane_data[15]}}, lane_data[15:0]};
            riscv_pkg::LS_HU: ext_data = {16'b0, lane_data[15:0]};
            default:          ext_data = mem_ld;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= exec_pkg::MEM_IDLE;
        end else begin
            case (state)
                exec_pkg::MEM_IDLE: begin
                    if (start) begin
                        state <= is_store ? exec_pkg::MEM_DONE : exec_pkg::MEM_READ;
                    end
                end
                exec_pkg::MEM_READ: state <= exec_pkg::MEM_DONE;
                default:            state <= exec_pkg::MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            f3_q  <= func3;
            off_q <= addr[1:0];
            // stores return zero
            rdata <= '0;
        end else if (state == exec_pkg::MEM_READ) begin
            rdata <= ext_data;
        end
    end

    assign done = (state == exec_pkg::MEM_DONE);

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit #(
    parameter int PREG_W  = 6,
    parameter int CTX_W   = 4,
    parameter int MADDR_W = 10
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          order,
    output logic                          accepted,
    input  exec_pkg::exec_type_e          exec_type,
    input  logic [2:0]                    func3,
    input  logic [6:0]                    func7,
    input  logic [PREG_W-1:0]             pa_rd,
    input  logic [riscv_pkg::XLEN-1:0]    d_rs1,
    input  logic [riscv_pkg::XLEN-1:0]    d_rs2,
    input  logic [CTX_W-1:0]              ctx,
    input  logic [CTX_W-1:0]              b_t_ctx,
    input  logic [CTX_W-1:0]              b_f_ctx,
    output logic                          wr_valid,
    output logic [PREG_W-1:0]             wr_pa,
    output logic [riscv_pkg::XLEN-1:0]    wr_data,
    output logic                          jump_valid,
    output logic [CTX_W-1:0]              jump_ctx,
    output logic [riscv_pkg::XLEN-1:0]    jump_pc,
    output logic                          br_valid,
    output logic [CTX_W-1:0]              br_ctx,
    output logic [CTX_W-1:0]              br_miss_ctx,
    output logic [CTX_W-1:0]              br_safe_ctx,
    output logic                          mem_en,
    output logic [3:0]                    mem_write,
    output logic [MADDR_W-1:0]            mem_a,
    output logic [riscv_pkg::XLEN-1:0]    mem_sd,
    input  logic [riscv_pkg::XLEN-1:0]    mem_ld
);

    logic                       busy;
    logic                       done;
    logic [PREG_W-1:0]          pa_q;
    logic                       alu_start;
    logic                       mul_start;
    logic                       mem_start;
    logic                       jump_start;
    logic                       br_start;
    logic                       subst_start;
    logic                       mul_done;
    logic                       mem_done;
    logic                       taken;
    logic [riscv_pkg::XLEN-1:0] alu_y;
    logic [riscv_pkg::XLEN-1:0] mul_y;
    logic [riscv_pkg::XLEN-1:0] mem_y;
    logic [riscv_pkg::XLEN-1:0] result;

    assign accepted    = order & ~busy;
    assign alu_start   = accepted & (exec_type == exec_pkg::EX_ALU);
    assign mul_start   = accepted & (exec_type == exec_pkg::EX_MUL);
    assign mem_start   = accepted & ((exec_type == exec_pkg::EX_LOAD) |
                                     (exec_type == exec_pkg::EX_STORE));
    assign jump_start  = accepted & (exec_type == exec_pkg::EX_JUMP);
    assign br_start    = accepted & (exec_type == exec_pkg::EX_BRANCH);
    assign subst_start = accepted & (exec_type == exec_pkg::EX_SUBST);

    alu alu_i (
        .func3 (func3),
        .func7 (func7),
        .a     (d_rs1),
        .b     (d_rs2),
        .y     (alu_y)
    );

    alu_mul alu_mul_i (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .func3 (func3),
        .a     (d_rs1),
        .b     (d_rs2),
        .done  (mul_done),
        .y     (mul_y)
    );

    branch_cmp branch_cmp_i (
        .func3 (func3),
        .a     (d_rs1),
        .b     (d_rs2),
        .taken (taken)
    );

    mem_access #(
        .MADDR_W (MADDR_W)
    ) mem_access_i (
        .clk       (clk),
        .rst       (rst),
        .start     (mem_start),
        .is_store  (exec_type == exec_pkg::EX_STORE),
        .func3     (func3),
        .addr      (d_rs1),
        .sdata     (d_rs2),
        .mem_ld    (mem_ld),
        .done      (mem_done),
        .rdata     (mem_y),
        .mem_en    (mem_en),
        .mem_write (mem_write),
        .mem_a     (mem_a),
        .mem_sd    (mem_sd)
    );

    // single-cycle units finish in their start cycle
    assign done = alu_start | mul_done | mem_done | jump_start | br_start | subst_start;

    assign result = alu_start   ? alu_y :
                    mul_done    ? mul_y :
                    mem_done    ? mem_y :
                    jump_start  ? d_rs2 :
                    subst_start ? d_rs1 :
                    '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            wr_valid   <= 1'b0;
            jump_valid <= 1'b0;
            br_valid   <= 1'b0;
        end else begin
            busy       <= ~done & (busy | accepted);
            wr_valid   <= done;
            jump_valid <= jump_start;
            br_valid   <= br_start;
        end
    end

    always_ff @(posedge clk) begin
        if (accepted) begin
            pa_q <= pa_rd;
        end
        if (done) begin
            wr_pa   <= accepted ? pa_rd : pa_q;
            wr_data <= result;
        end
        if (jump_start) begin
            jump_ctx <= ctx;
            jump_pc  <= d_rs1;
        end
        if (br_start) begin
            br_ctx      <= ctx;
            br_safe_ctx <= taken ? b_t_ctx : b_f_ctx;
            br_miss_ctx <= taken ? b_f_ctx : b_t_ctx;
        end
    end

endmodule

`default_nettype wire

//--- verification/data_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem_model #(
    parameter int MADDR_W = 10
) (
    input  logic               clk,
    input  logic               mem_en,
    input  logic [3:0]         mem_write,
    input  logic [MADDR_W-1:0] mem_a,
    input  logic [31:0]        mem_sd,
    output logic [31:0]        mem_ld
);

    logic [31:0] mem [0:(1<<MADDR_W)-1];

    // fill pattern built from the full word address
    initial begin
        for (int i = 0; i < (1 << MADDR_W); i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
        end
    end

    always @(posedge clk) begin
        if (mem_en) begin
            if (mem_write == 4'b0000) begin
                mem_ld <= mem[mem_a];
            end
            for (int k = 0; k < 4; k++) begin
                if (mem_write[k]) begin
                    mem[mem_a][8*k +: 8] <= mem_sd[8*k +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

    localparam int PREG_W  = 6;
    localparam int CTX_W   = 4;
    localparam int MADDR_W = 8;
    localparam int TIMEOUT = 100;

    typedef struct {
        exec_pkg::exec_type_e etype;
        logic [2:0]           f3;
        logic [6:0]           f7;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [PREG_W-1:0]    pa;
        logic [CTX_W-1:0]     ctx;
        logic [CTX_W-1:0]     tctx;
        logic [CTX_W-1:0]     fctx;
        logic [31:0]          exp_data;
        logic                 exp_taken;
    } entry_t;

    logic clk = 1'b0;
    logic rst;
    logic order;
    logic accepted;
    exec_pkg::exec_type_e exec_type;
    logic [2:0] func3;
    logic [6:0] func7;
    logic [PREG_W-1:0] pa_rd;
    logic [31:0] d_rs1;
    logic [31:0] d_rs2;
    logic [CTX_W-1:0] ctx;
    logic [CTX_W-1:0] b_t_ctx;
    logic [CTX_W-1:0] b_f_ctx;
    logic wr_valid;
    logic [PREG_W-1:0] wr_pa;
    logic [31:0] wr_data;
    logic jump_valid;
    logic [CTX_W-1:0] jump_ctx;
    logic [31:0] jump_pc;
    logic br_valid;
    logic [CTX_W-1:0] br_ctx;
    logic [CTX_W-1:0] br_miss_ctx;
    logic [CTX_W-1:0] br_safe_ctx;
    logic mem_en;
    logic [3:0] mem_write;
    logic [MADDR_W-1:0] mem_a;
    logic [31:0] mem_sd;
    logic [31:0] mem_ld;

    entry_t      table_q[$];
    logic [7:0]  mirror [0:(4<<MADDR_W)-1];
    logic [31:0] lfsr = 32'hbe4c_e8a4;
    int          errors = 0;
    int          tests = 0;
    bit          test_ok;

    exec_unit #(
        .PREG_W  (PREG_W),
        .CTX_W   (CTX_W),
        .MADDR_W (MADDR_W)
    ) exec_unit_i (
        .clk(clk), .rst(rst), .order(order), .accepted(accepted),
        .exec_type(exec_type), .func3(func3), .func7(func7), .pa_rd(pa_rd),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .ctx(ctx), .b_t_ctx(b_t_ctx), .b_f_ctx(b_f_ctx),
        .wr_valid(wr_valid), .wr_pa(wr_pa), .wr_data(wr_data),
        .jump_valid(jump_valid), .jump_ctx(jump_ctx), .jump_pc(jump_pc),
        .br_valid(br_valid), .br_ctx(br_ctx), .br_miss_ctx(br_miss_ctx),
        .br_safe_ctx(br_safe_ctx), .mem_en(mem_en), .mem_write(mem_write),
        .mem_a(mem_a), .mem_sd(mem_sd), .mem_ld(mem_ld)
    );

    data_mem_model #(
        .MADDR_W (MADDR_W)
    ) data_mem_model_i (
        .clk(clk), .mem_en(mem_en), .mem_write(mem_write),
        .mem_a(mem_a), .mem_sd(mem_sd), .mem_ld(mem_ld)
    );

    always #10 clk = ~clk;

    // one LFSR step per bit
    function logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return w;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [6:0] f7,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a};
        case (f3)
            3'd0: return (f7 == 7'h20) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return (f7 == 7'h20) ? 32'(ext >> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] mul_ref(input logic [2:0] f3,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        // sign-extend per operand so the low 64 bits of the product are exact
        ea = (f3 == 3'd1 || f3 == 3'd2) ? {{32{a[31]}}, a} : {32'b0, a};
        eb = (f3 == 3'd1) ? {{32{b[31]}}, b} : {32'b0, b};
        p = ea * eb;
        return (f3 == 3'd0) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3,
                                        input logic [31:0] a, input logic [31:0] b);
        logic lt;
        lt = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return lt;
            3'd5: return !lt;
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] mirror_load(input logic [2:0] f3, input int ba);
        case (f3)
            3'd0: return {{24{mirror[ba][7]}}, mirror[ba]};
            3'd4: return {24'b0, mirror[ba]};
            3'd1: return {{16{mirror[ba+1][7]}}, mirror[ba+1], mirror[ba]};
            3'd5: return {16'b0, mirror[ba+1], mirror[ba]};
            default: return {mirror[ba+3], mirror[ba+2], mirror[ba+1], mirror[ba]};
        endcase
    endfunction

    task automatic add_entry(input exec_pkg::exec_type_e t, input logic [2:0] f3,
                             input logic [6:0] f7, input logic [31:0] a, input logic [31:0] b);
        entry_t e;
        int     ba;
        int     n;
        n = table_q.size();
        ba = int'(a[MADDR_W+1:0]);
        e.etype = t;
        e.f3 = f3;
        e.f7 = f7;
        e.a = a;
        e.b = b;
        e.pa = PREG_W'(n + 1);
        e.ctx = CTX_W'(n);
        e.tctx = CTX_W'(n + 3);
        e.fctx = CTX_W'(n + 7);
        e.exp_taken = branch_ref(f3, a, b);
        e.exp_data = '0;
        case (t)
            exec_pkg::EX_ALU:   e.exp_data = alu_ref(f3, f7, a, b);
            exec_pkg::EX_MUL:   e.exp_data = mul_ref(f3, a, b);
            exec_pkg::EX_LOAD:  e.exp_data = mirror_load(f3, ba);
            exec_pkg::EX_JUMP:  e.exp_data = b;
            exec_pkg::EX_SUBST: e.exp_data = a;
            exec_pkg::EX_STORE: begin
                mirror[ba] = b[7:0];
                if (f3 != 3'd0) begin
                    mirror[ba+1] = b[15:8];
                end
                if (f3 == 3'd2) begin
                    mirror[ba+2] = b[23:16];
                    mirror[ba+3] = b[31:24];
                end
            end
            default: ;
        endcase
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] edge_a [3];
        logic [31:0] edge_b [3];
        logic [2:0]  br_f3 [6];
        edge_a = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
        edge_b = '{32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
        br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int f = 0; f < 8; f++) begin
            add_entry(exec_pkg::EX_ALU, 3'(f), 7'h00, rand_word(), rand_word());
        end
        add_entry(exec_pkg::EX_ALU, 3'd0, riscv_pkg::F7_ALT, rand_word(), rand_word());
        add_entry(exec_pkg::EX_ALU, 3'd5, riscv_pkg::F7_ALT, 32'h8000_00f0, 32'd7);
        add_entry(exec_pkg::EX_SUBST, 3'd0, 7'h00, rand_word(), 32'd0);
        for (int f = 0; f < 4; f++) begin
            add_entry(exec_pkg::EX_MUL, 3'(f), 7'h00, rand_word(), rand_word());
            for (int k = 0; k < 3; k++) begin
                add_entry(exec_pkg::EX_MUL, 3'(f), 7'h00, edge_a[k], edge_b[k]);
            end
        end
        add_entry(exec_pkg::EX_STORE, 3'd2, 7'h00, 32'h40, 32'h8091_a2b3);
        add_entry(exec_pkg::EX_STORE, 3'd2, 7'h00, 32'h44, rand_word());
        add_entry(exec_pkg::EX_STORE, 3'd1, 7'h00, 32'h44, 32'h0000_9abc);
        add_entry(exec_pkg::EX_STORE, 3'd1, 7'h00, 32'h46, 32'h0000_7f01);
        add_entry(exec_pkg::EX_STORE, 3'd0, 7'h00, 32'h41, 32'h0000_00c5);
        add_entry(exec_pkg::EX_STORE, 3'd0, 7'h00, 32'h43, 32'h0000_0012);
        add_entry(exec_pkg::EX_LOAD, 3'd2, 7'h00, 32'h40, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd2, 7'h00, 32'h44, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd1, 7'h00, 32'h44, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd5, 7'h00, 32'h44, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd1, 7'h00, 32'h46, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd0, 7'h00, 32'h41, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd4, 7'h00, 32'h41, 32'd0);
        add_entry(exec_pkg::EX_LOAD, 3'd0, 7'h00, 32'h43, 32'd0);
        for (int k = 0; k < 6; k++) begin
            add_entry(exec_pkg::EX_BRANCH, br_f3[k], 7'h00, 32'hffff_fffb, 32'd3);
            add_entry(exec_pkg::EX_BRANCH, br_f3[k], 7'h00, 32'd9, 32'd9);
            add_entry(exec_pkg::EX_BRANCH, br_f3[k], 7'h00, 32'd3, 32'hffff_fffb);
        end
        add_entry(exec_pkg::EX_JUMP, 3'd0, 7'h00, 32'h0000_1230, 32'h0000_0a04);
    endtask

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED t=%0t %s", $time, msg);
        errors++;
        test_ok = 0;
    endtask

    task automatic drive_order(input entry_t e);
        order = 1'b1;
        exec_type = e.etype;
        func3 = e.f3;
        func7 = e.f7;
        pa_rd = e.pa;
        d_rs1 = e.a;
        d_rs2 = e.b;
        ctx = e.ctx;
        b_t_ctx = e.tctx;
        b_f_ctx = e.fctx;
    endtask

    // wait at +3 ns after each edge for a signal, up to TIMEOUT cycles
    task automatic wait_accept(output int cycles);
        cycles = 0;
        #1;
        while (!accepted && cycles < TIMEOUT) begin
            @(posedge clk);
            #3;
            cycles++;
        end
        if (!accepted) begin
            $display("timeout: order was never accepted");
            errors++;
            test_ok = 0;
        end
    endtask

    task automatic wait_write(output int cycles);
        cycles = 1;
        while (!wr_valid && cycles < TIMEOUT) begin
            @(posedge clk);
            #3;
            cycles++;
        end
        if (!wr_valid) begin
            $display("timeout: no write-back arrived");
            errors++;
            test_ok = 0;
        end
    endtask

    task automatic run_entry(input entry_t e, input int idx);
        int wait_c;
        int lat;
        int exp_lat;
        test_ok = 1;
        exp_lat = (e.etype == exec_pkg::EX_STORE) ? 2 :
                  (e.etype == exec_pkg::EX_LOAD) ? 3 :
                  (e.etype == exec_pkg::EX_MUL) ? 0 : 1;
        @(posedge clk);
        #2;
        drive_order(e);
        wait_accept(wait_c);
        @(posedge clk);
        #2;
        order = 1'b0;
        // the window is free to reuse its fields after accept
        func3 = ~e.f3;
        pa_rd = ~e.pa;
        d_rs1 = ~e.a;
        d_rs2 = ~e.b;
        #1;
        wait_write(lat);
        if (wr_data !== e.exp_data) begin
            flag_mismatch($sformatf("wr_data %h expected %h", wr_data, e.exp_data));
        end
        if (wr_pa !== e.pa) begin
            flag_mismatch($sformatf("wr_pa %0d expected %0d", wr_pa, e.pa));
        end
        if (exp_lat != 0 && lat != exp_lat) begin
            flag_mismatch($sformatf("latency %0d expected %0d", lat, exp_lat));
        end
        if (jump_valid !== (e.etype == exec_pkg::EX_JUMP) ||
            br_valid !== (e.etype == exec_pkg::EX_BRANCH)) begin
            flag_mismatch($sformatf("jump_valid %b br_valid %b", jump_valid, br_valid));
        end
        if (e.etype == exec_pkg::EX_BRANCH) begin
            if (br_ctx !== e.ctx) begin
                flag_mismatch($sformatf("br_ctx %0d expected %0d", br_ctx, e.ctx));
            end
            if (br_safe_ctx !== (e.exp_taken ? e.tctx : e.fctx) ||
                br_miss_ctx !== (e.exp_taken ? e.fctx : e.tctx)) begin
                flag_mismatch($sformatf("branch safe/miss %0d/%0d", br_safe_ctx, br_miss_ctx));
            end
        end
        if (e.etype == exec_pkg::EX_JUMP) begin
            if (jump_pc !== e.a || jump_ctx !== e.ctx) begin
                flag_mismatch($sformatf("jump report pc %h ctx %0d", jump_pc, jump_ctx));
            end
        end
        @(posedge clk);
        #3;
        if (wr_valid) begin
            flag_mismatch("wr_valid high for more than one cycle");
        end
        tests++;
        $display("test %0d %s %s", idx, e.etype.name(), test_ok ? "ok" : "fail");
    endtask

    // back-to-back ALU orders and a MUL holding off an ALU order
    task automatic run_stream_and_stall();
        entry_t x;
        entry_t y;
        int     c;
        test_ok = 1;
        x = table_q[0];
        y = table_q[1];
        @(posedge clk);
        #2;
        drive_order(x);
        wait_accept(c);
        @(posedge clk);
        #2;
        drive_order(y);
        #1;
        if (!accepted || !wr_valid || wr_data !== x.exp_data || wr_pa !== x.pa) begin
            flag_mismatch("first streamed write-back wrong");
        end
        @(posedge clk);
        #2;
        drive_order(table_q[12]);
        #1;
        if (!wr_valid || wr_data !== y.exp_data || wr_pa !== y.pa) begin
            flag_mismatch("second streamed write-back wrong");
        end
        @(posedge clk);
        #2;
        drive_order(x);
        c = 0;
        #1;
        while (!wr_valid && c < TIMEOUT) begin
            if (accepted) begin
                flag_mismatch("order accepted while multiply busy");
            end
            @(posedge clk);
            #3;
            c++;
        end
        if (!wr_valid || wr_data !== table_q[12].exp_data || wr_pa !== table_q[12].pa ||
            !accepted) begin
            flag_mismatch("multiply result or release after stall wrong");
        end
        @(posedge clk);
        #2;
        order = 1'b0;
        #1;
        if (!wr_valid || wr_data !== x.exp_data || wr_pa !== x.pa) begin
            flag_mismatch("held order write-back wrong");
        end
        tests++;
        $display("test stream/stall %s", test_ok ? "ok" : "fail");
    endtask

    initial begin
        entry_t e;
        rst = 1'b1;
        e = '{etype: exec_pkg::EX_ALU, default: '0};
        drive_order(e);
        order = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        #1;
        test_ok = 1;
        if (accepted || wr_valid || jump_valid || br_valid || mem_en || mem_write != 4'b0) begin
            flag_mismatch("outputs not idle after reset");
        end
        tests++;
        $display("test reset %s", test_ok ? "ok" : "fail");
        for (int i = 0; i < table_q.size(); i++) begin
            run_entry(table_q[i], i);
        end
        run_stream_and_stall();
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
common/riscv_pkg.sv
common/exec_pkg.sv
alu/alu.sv
alu/alu_mul.sv
design/branch_cmp.sv
design/mem_access.sv
design/exec_unit.sv
verification/data_mem_model.sv
verification/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the execute stage testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module exec_tb -f tb.f -o exec_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/exec_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
